//--- verilog/lb_isa_pkg.sv
package lb_isa_pkg;

	// lc-3b machine word, data and byte addresses alike
	localparam int lb_word_width = 16;

	typedef logic [lb_word_width-1:0] lb_word_t;

	// external fill port into the data memory
	// addr is a byte address, bit 0 dropped by the memory
	typedef struct packed {
		// write strobe
		logic en;
		// byte address of the word
		lb_word_t addr;
		// full 16-bit word to store
		lb_word_t data;
	} lb_mem_wr_t;

endpackage : lb_isa_pkg

//--- verilog/lb_ooo_pkg.sv
package lb_ooo_pkg;

	import lb_isa_pkg::*;

	// rob has eight slots
	localparam int lb_rob_tag_width = 3;

	// names a producer or a destination in the rob
	typedef logic [lb_rob_tag_width-1:0] lb_rob_tag_t;

	// one load from the dispatch stage
	// tag only meaningful while ready is low
	typedef struct packed {
		logic push;
		logic ready;
		lb_rob_tag_t tag;
		lb_word_t base;
		lb_word_t offset;
		lb_rob_tag_t dest;
	} lb_dispatch_t;

	// single broadcast per cycle on the common data bus
	typedef struct packed {
		logic valid;
		lb_rob_tag_t tag;
		lb_word_t value;
	} lb_cdb_t;

	// completed load toward the rob
	typedef struct packed {
		logic valid;
		lb_rob_tag_t dest;
		lb_word_t data;
	} lb_result_t;

	// stored load buffer slot
	typedef struct packed {
		logic ready;
		lb_rob_tag_t tag;
		lb_word_t base;
		lb_word_t offset;
		lb_rob_tag_t dest;
	} lb_entry_t;

endpackage : lb_ooo_pkg

//--- verilog/load_buffer_data.sv
module load_buffer_data
	import lb_isa_pkg::*, lb_ooo_pkg::*;
#(
	parameter int entries_addr = 2,
	localparam int depth = 2 ** entries_addr
)
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic push,
	input lb_entry_t push_entry,
	input logic pop,
	input logic [depth-1:0] wake_mask,
	input lb_word_t wake_value,
	output lb_entry_t head,
	output logic [depth-1:0] entry_ready,
	output lb_rob_tag_t [depth-1:0] entry_tag,
	output logic empty,
	output logic full
);

	// circular pointers, one slot kept spare
	logic [entries_addr-1:0] rd_ptr;
	logic [entries_addr-1:0] wr_ptr;
	// number of live entries
	logic [entries_addr-1:0] fill;

	logic [depth-1:0] ready_q;
	// slots between head and tail
	logic [depth-1:0] occupied;
	// wakeups that land on live slots
	logic [depth-1:0] wake_hit;
	logic do_push;
	logic do_pop;

	// payload storage
	lb_rob_tag_t tag_q [depth];
	lb_word_t base_q [depth];
	lb_word_t offset_q [depth];
	lb_rob_tag_t dest_q [depth];

	assign empty = rd_ptr == wr_ptr;
	assign full = (wr_ptr + 1'b1) == rd_ptr;
	assign fill = wr_ptr - rd_ptr;

	// guard against stray strobes
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// distance from head decides liveness
	always_comb
	begin
		for (int i = 0; i < depth; i++)
		begin
			occupied[i] = (entries_addr'(i) - rd_ptr) < fill;
		end
	end

	// stale slots may match a cdb tag, drop those
	assign wake_hit = wake_mask & occupied;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			ready_q <= '0;
		end
		else if (flush)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			ready_q <= '0;
		end
		else
		begin
			// wakeup first
			ready_q <= ready_q | wake_hit;
			// popped slot goes back to not ready
			if (do_pop)
			begin
				ready_q[rd_ptr] <= 1'b0;
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push last so it beats a wakeup on the tail slot
			if (do_push)
			begin
				ready_q[wr_ptr] <= push_entry.ready;
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		// captured operand replaces base
		for (int i = 0; i < depth; i++)
		begin
			if (wake_hit[i])
			begin
				base_q[i] <= wake_value;
			end
		end
		if (do_push)
		begin
			tag_q[wr_ptr] <= push_entry.tag;
			base_q[wr_ptr] <= push_entry.base;
			offset_q[wr_ptr] <= push_entry.offset;
			dest_q[wr_ptr] <= push_entry.dest;
		end
	end

	// head view and per-slot snoop info
	always_comb
	begin
		head.ready = ready_q[rd_ptr];
		head.tag = tag_q[rd_ptr];
		head.base = base_q[rd_ptr];
		head.offset = offset_q[rd_ptr];
		head.dest = dest_q[rd_ptr];
		for (int i = 0; i < depth; i++)
		begin
			entry_tag[i] = tag_q[i];
		end
	end

	assign entry_ready = ready_q;

	// ctrl must only pop a live head
	pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
		else $error("pop while load buffer empty");

	// ctrl must hold back dispatch when full
	push_not_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
		else $error("push while load buffer full");

endmodule : load_buffer_data

//--- verilog/load_buffer_ctrl.sv
module load_buffer_ctrl
	import lb_isa_pkg::*, lb_ooo_pkg::*;
#(
	parameter int entries_addr = 2,
	localparam int depth = 2 ** entries_addr
)
(
	input lb_dispatch_t dispatch,
	input lb_cdb_t cdb,
	input lb_entry_t head,
	input logic [depth-1:0] entry_ready,
	input lb_rob_tag_t [depth-1:0] entry_tag,
	input logic empty,
	input logic full,
	output logic push,
	output lb_entry_t push_entry,
	output logic pop,
	output logic [depth-1:0] wake_mask,
	output lb_word_t wake_value,
	output logic rd_en,
	output lb_word_t rd_addr,
	output lb_rob_tag_t rd_dest
);

	// broadcast hits the load being dispatched right now
	logic fwd_hit;

	assign fwd_hit = cdb.valid && !dispatch.ready && (dispatch.tag == cdb.tag);

	// overflowing pushes are lost
	assign push = dispatch.push && !full;

	// new entry with operand bypassed from the cdb
	always_comb
	begin
		push_entry.ready = dispatch.ready || fwd_hit;
		push_entry.tag = dispatch.tag;
		push_entry.base = fwd_hit ? cdb.value : dispatch.base;
		push_entry.offset = dispatch.offset;
		push_entry.dest = dispatch.dest;
	end

	// tag match on every slot still waiting
	always_comb
	begin
		for (int i = 0; i < depth; i++)
		begin
			wake_mask[i] = cdb.valid && !entry_ready[i] && (entry_tag[i] == cdb.tag);
		end
	end

	assign wake_value = cdb.value;

	// in-order issue from the head only
	assign pop = !empty && head.ready;
	assign rd_en = pop;

	// effective address wraps at 16 bits
	assign rd_addr = head.base + head.offset;
	assign rd_dest = head.dest;

endmodule : load_buffer_ctrl

//--- verilog/load_data_mem.sv
module load_data_mem
	import lb_isa_pkg::*, lb_ooo_pkg::*;
#(
	parameter int mem_addr_width = 8
)
(
	input logic clk,
	input logic arst_n,
	input lb_mem_wr_t mem_wr,
	input logic rd_en,
	input lb_word_t rd_addr,
	input lb_rob_tag_t rd_dest,
	output lb_result_t result
);

	// word indices with byte bit 0 dropped
	logic [mem_addr_width-1:0] wr_word;
	logic [mem_addr_width-1:0] rd_word;

	// word array with contents unknown until filled
	lb_word_t mem [2 ** mem_addr_width];

	// result stage
	logic valid_q;
	lb_rob_tag_t dest_q;
	lb_word_t data_q;

	assign wr_word = mem_wr.addr[mem_addr_width:1];
	assign rd_word = rd_addr[mem_addr_width:1];

	// read sees the old word on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (mem_wr.en)
		begin
			mem[wr_word] <= mem_wr.data;
		end
		if (rd_en)
		begin
			data_q <= mem[rd_word];
			dest_q <= rd_dest;
		end
	end

	// one strobe per issued load
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= rd_en;
		end
	end

	assign result = '{valid: valid_q, dest: dest_q, data: data_q};

	// issued loads need a defined word index
	rd_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
		rd_en |-> !$isunknown(rd_word))
		else $error("load issued with an unknown address");

endmodule : load_data_mem

//--- verilog/load_unit.sv
module load_unit
	import lb_isa_pkg::*, lb_ooo_pkg::*;
#(
	parameter int entries_addr = 2,
	parameter int mem_addr_width = 8
)
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input lb_dispatch_t dispatch,
	input lb_cdb_t cdb,
	input lb_mem_wr_t mem_wr,
	output lb_result_t result,
	output logic full,
	output logic empty
);

	localparam int depth = 2 ** entries_addr;

	// ctrl to buffer
	logic push;
	lb_entry_t push_entry;
	logic pop;
	logic [depth-1:0] wake_mask;
	lb_word_t wake_value;

	// buffer to ctrl
	lb_entry_t head;
	logic [depth-1:0] entry_ready;
	lb_rob_tag_t [depth-1:0] entry_tag;

	// ctrl to memory
	logic rd_en;
	lb_word_t rd_addr;
	lb_rob_tag_t rd_dest;

	// entry storage
	load_buffer_data #(
		.entries_addr(entries_addr)
	) buf0 (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.push(push),
		.push_entry(push_entry),
		.pop(pop),
		.wake_mask(wake_mask),
		.wake_value(wake_value),
		.head(head),
		.entry_ready(entry_ready),
		.entry_tag(entry_tag),
		.empty(empty),
		.full(full)
	);

	// snoop, forward, issue
	load_buffer_ctrl #(
		.entries_addr(entries_addr)
	) ctrl0 (
		.dispatch(dispatch),
		.cdb(cdb),
		.head(head),
		.entry_ready(entry_ready),
		.entry_tag(entry_tag),
		.empty(empty),
		.full(full),
		.push(push),
		.push_entry(push_entry),
		.pop(pop),
		.wake_mask(wake_mask),
		.wake_value(wake_value),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_dest(rd_dest)
	);

	// data memory and result register
	load_data_mem #(
		.mem_addr_width(mem_addr_width)
	) mem0 (
		.clk(clk),
		.arst_n(arst_n),
		.mem_wr(mem_wr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_dest(rd_dest),
		.result(result)
	);

endmodule : load_unit

//--- testbench/load_unit_tb.sv
module load_unit_tb
	import lb_isa_pkg::*, lb_ooo_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int entries_addr = 2;
	localparam int mem_addr_width = 8;
	localparam int mem_words = 2 ** mem_addr_width;
	// roughly four times the summed test length
	localparam int max_cycles = 2000;
	// cycles allowed for a batch of loads to drain
	localparam int drain_limit = 40;

	logic clk;
	logic arst_n;
	logic flush;
	lb_dispatch_t dispatch;
	lb_cdb_t cdb;
	lb_mem_wr_t mem_wr;
	lb_result_t result;
	logic full;
	logic empty;

	// reference copy of the data memory
	lb_word_t model_mem [mem_words];
	// loads still owed by the dut, push order
	lb_result_t exp_q [$];

	logic [31:0] lcg_state = 32'd27910;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int result_count = 0;
	int last_result_cycle = 0;

	load_unit #(
		.entries_addr(entries_addr),
		.mem_addr_width(mem_addr_width)
	) dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.dispatch(dispatch),
		.cdb(cdb),
		.mem_wr(mem_wr),
		.result(result),
		.full(full),
		.empty(empty)
	);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
	end

	function automatic lb_word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// word index is the effective address from bit 1 up
	function automatic lb_result_t model_load(lb_word_t base, lb_word_t offset, lb_rob_tag_t dest);
		lb_word_t ea;
		lb_result_t res;
		ea = base + offset;
		res.valid = 1'b1;
		res.dest = dest;
		res.data = model_mem[ea[mem_addr_width:1]];
		return res;
	endfunction

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic report_failure(string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	// one edge, then strobes drop 1 ns later
	task automatic tick();
		@(posedge clk);
		#1;
		dispatch.push = 1'b0;
		cdb.valid = 1'b0;
		flush = 1'b0;
		mem_wr.en = 1'b0;
	endtask

	task automatic idle(int n);
		repeat (n) tick();
	endtask

	task automatic set_load(logic ready, lb_rob_tag_t tag, lb_word_t base, lb_word_t offset,
		lb_rob_tag_t dest);
		dispatch = '{push: 1'b1, ready: ready, tag: tag, base: base, offset: offset, dest: dest};
	endtask

	task automatic set_broadcast(lb_rob_tag_t tag, lb_word_t value);
		cdb = '{valid: 1'b1, tag: tag, value: value};
	endtask

	// model follows every write
	task automatic write_word(int idx, lb_word_t data);
		mem_wr = '{en: 1'b1, addr: lb_word_t'(idx) << 1, data: data};
		model_mem[idx] = data;
		tick();
	endtask

	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < drain_limit)
		begin
			tick();
			waited++;
		end
		if (exp_q.size() > 0)
		begin
			report_failure($sformatf("missing result, %0d loads never completed", exp_q.size()));
			exp_q.delete();
		end
		// quiet cycles expose a stray strobe
		idle(2);
	endtask

	// result is registered, stable at the falling edge
	always @(negedge clk)
	begin : monitor
		lb_result_t exp_res;
		if (arst_n && result.valid)
		begin
			result_count++;
			last_result_cycle = cycles;
			if (exp_q.size() == 0)
			begin
				report_failure($sformatf("unexpected result for dest %0d", result.dest));
			end
			else
			begin
				exp_res = exp_q.pop_front();
				check_value("result.dest", result.dest, exp_res.dest);
				check_value("result.data", result.data, exp_res.data);
			end
		end
	end

	task automatic test_ready_loads();
		lb_word_t base;
		lb_word_t offset;
		int push_cycle;
		for (int i = 0; i < mem_words; i++)
		begin
			write_word(i, lcg_next());
		end
		// lone load for the latency check
		base = lcg_next();
		offset = lcg_next();
		set_load(1'b1, '0, base, offset, 3'd0);
		exp_q.push_back(model_load(base, offset, 3'd0));
		push_cycle = cycles;
		tick();
		wait_results();
		check_value("first result latency", last_result_cycle - push_cycle, 2);
		// back to back, wraparound addresses included
		for (int i = 1; i < 7; i++)
		begin
			base = lcg_next();
			offset = lcg_next();
			set_load(1'b1, '0, base, offset, lb_rob_tag_t'(i));
			exp_q.push_back(model_load(base, offset, lb_rob_tag_t'(i)));
			tick();
		end
		wait_results();
		check_value("empty", empty, 1'b1);
	endtask

	task automatic test_cdb_wakeup();
		int count0;
		count0 = result_count;
		// stale base on the head, must be replaced
		set_load(1'b0, 3'd1, 16'hdead, 16'h0010, 3'd4);
		tick();
		set_load(1'b0, 3'd2, '0, 16'h0022, 3'd5);
		tick();
		set_load(1'b0, 3'd3, '0, 16'h0104, 3'd6);
		tick();
		// younger entries wake first
		set_broadcast(3'd3, 16'h0040);
		tick();
		idle(2);
		set_broadcast(3'd2, 16'h1230);
		tick();
		idle(2);
		check_value("result_count", result_count, count0);
		set_broadcast(3'd1, 16'h0300);
		exp_q.push_back(model_load(16'h0300, 16'h0010, 3'd4));
		exp_q.push_back(model_load(16'h1230, 16'h0022, 3'd5));
		exp_q.push_back(model_load(16'h0040, 16'h0104, 3'd6));
		tick();
		wait_results();
	endtask

	task automatic test_shared_tag();
		set_load(1'b0, 3'd5, '0, 16'h0006, 3'd1);
		tick();
		set_load(1'b0, 3'd5, '0, 16'h0100, 3'd2);
		tick();
		idle(1);
		// third load meets its broadcast at dispatch
		set_load(1'b0, 3'd5, '0, 16'h0031, 3'd3);
		set_broadcast(3'd5, 16'h0a00);
		exp_q.push_back(model_load(16'h0a00, 16'h0006, 3'd1));
		exp_q.push_back(model_load(16'h0a00, 16'h0100, 3'd2));
		exp_q.push_back(model_load(16'h0a00, 16'h0031, 3'd3));
		tick();
		wait_results();
	endtask

	task automatic test_full_overflow();
		lb_result_t b_res;
		lb_result_t c_res;
		lb_word_t base;
		check_value("full", full, 1'b0);
		// head blocks the queue
		set_load(1'b0, 3'd7, '0, 16'h0010, 3'd0);
		tick();
		base = lcg_next();
		set_load(1'b1, '0, base, 16'h0002, 3'd1);
		b_res = model_load(base, 16'h0002, 3'd1);
		tick();
		check_value("full", full, 1'b0);
		base = lcg_next();
		set_load(1'b1, '0, base, 16'h0008, 3'd2);
		c_res = model_load(base, 16'h0008, 3'd2);
		tick();
		check_value("full", full, 1'b1);
		// dropped, one slot kept spare
		set_load(1'b1, '0, 16'h0044, 16'h0000, 3'd3);
		tick();
		check_value("full", full, 1'b1);
		set_broadcast(3'd7, 16'h0150);
		exp_q.push_back(model_load(16'h0150, 16'h0010, 3'd0));
		exp_q.push_back(b_res);
		exp_q.push_back(c_res);
		tick();
		wait_results();
		check_value("empty", empty, 1'b1);
		check_value("full", full, 1'b0);
	endtask

	task automatic test_flush();
		int count0;
		count0 = result_count;
		set_load(1'b0, 3'd2, '0, 16'h0012, 3'd1);
		tick();
		set_load(1'b0, 3'd3, '0, 16'h0014, 3'd2);
		tick();
		check_value("empty", empty, 1'b0);
		flush = 1'b1;
		tick();
		check_value("empty", empty, 1'b1);
		// tags of dropped loads, nothing may wake
		set_broadcast(3'd2, 16'h0070);
		tick();
		set_broadcast(3'd3, 16'h0072);
		tick();
		idle(4);
		check_value("result_count", result_count, count0);
		set_load(1'b1, '0, 16'h0090, 16'h0006, 3'd4);
		exp_q.push_back(model_load(16'h0090, 16'h0006, 3'd4));
		tick();
		wait_results();
		check_value("empty", empty, 1'b1);
	endtask

	task automatic test_mem_update();
		// byte 0xb4 is word 0x5a
		write_word(8'h5a, 16'hbeef);
		set_load(1'b1, '0, 16'h00b0, 16'h0004, 3'd6);
		exp_q.push_back(model_load(16'h00b0, 16'h0004, 3'd6));
		tick();
		wait_results();
		// odd address, same word
		write_word(8'h5a, 16'h1357);
		set_load(1'b1, '0, 16'h00b1, 16'h0004, 3'd7);
		exp_q.push_back(model_load(16'h00b1, 16'h0004, 3'd7));
		tick();
		wait_results();
	endtask

	initial
	begin
		arst_n = 1'b0;
		flush = 1'b0;
		dispatch = '0;
		cdb = '0;
		mem_wr = '0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_value("result.valid", result.valid, 1'b0);
		check_value("empty", empty, 1'b1);
		check_value("full", full, 1'b0);
		test_ready_loads();
		test_cdb_wakeup();
		test_shared_tag();
		test_full_overflow();
		test_flush();
		test_mem_update();
		finish_run();
	end

	initial
	begin
		wait (cycles >= max_cycles);
		report_failure($sformatf("timeout after %0d cycles, tests did not finish", cycles));
		finish_run();
	end

endmodule : load_unit_tb

//--- src.f
verilog/lb_isa_pkg.sv
verilog/lb_ooo_pkg.sv
verilog/load_buffer_data.sv
verilog/load_buffer_ctrl.sv
verilog/load_data_mem.sv
verilog/load_unit.sv
testbench/load_unit_tb.sv

//--- Bender.yml
package:
  name: load_unit

sources:
  # packages first, then rtl bottom up
  - verilog/lb_isa_pkg.sv
  - verilog/lb_ooo_pkg.sv
  - verilog/load_buffer_data.sv
  - verilog/load_buffer_ctrl.sv
  - verilog/load_data_mem.sv
  - verilog/load_unit.sv
  - target: test
    files:
      - testbench/load_unit_tb.sv
